//--- arLoadCtl.sv
`timescale 1ns/1ps

module arLoadCtl (
  ctlDecodeIf.user          dec,
  input  ctlPkg::regSelT    crmAr,
  input  ctlPkg::regSelT    crmArx,
  input  ctlPkg::crmMagicT  crmMagic,
  input  logic              mrReset,
  input  logic              mclLoadAr,
  input  logic              mclLoadArx,
  input  logic              mclMemArlInd,
  input  logic              mcl18BitEa,
  input  logic              mcl23BitEa,
  input  logic              fmXfer,
  input  logic              respMbox,
  input  logic              respSim,
  input  logic              arx18,
  input  ctlPkg::diagFuncT  diagFunc,
  output logic              ar00to08Load,
  output logic              ar09to17Load,
  output logic              arrLoad,
  output logic              arxLoad,
  output ctlPkg::regSelT    arlSel,
  output ctlPkg::regSelT    arrSel,
  output ctlPkg::regSelT    arxlSel,
  output ctlPkg::regSelT    arxrSel,
  output logic              ar00to11Clr,
  output logic              ar12to17Clr,
  output logic              arrClr,
  output logic              arxClr
);
  import ctlPkg::*;

  logic   arlInd, respAny, fmArLoad, fmArxLoad;
  logic   arClrSrc, shortEa, ea36, steerL, steerR, loadAny;
  regSelT regCtl, arlSrc;

  always_comb begin
    arlInd = mclMemArlInd | dec.arlInd | dec.arlIndCond;
    regCtl = crmMagic[0:2] & {3{dec.regCtl}};
    respAny = respMbox | respSim;
    fmArLoad = fmXfer & mclLoadAr;
    fmArxLoad = fmXfer & mclLoadArx;

    // Magic field takes over the ARL select and the clears
    arlSrc = arlInd ? {crmMagic[8], crmMagic[7], crmMagic[6]} : crmAr;
    arxClr = arlInd ? crmMagic[3] : dec.arxClr;
    arClrSrc = arlInd ? crmMagic[4] : dec.arClr;
    arrClr = arlInd ? crmMagic[5] : dec.arClr;

    // EA mode clears, short address on ARX bit 18
    shortEa = dec.eaMod & arx18;
    ar12to17Clr = mrReset | mcl18BitEa | arClrSrc | shortEa;
    ar00to11Clr = ar12to17Clr | mcl23BitEa;
    ea36 = dec.aread & ar00to11Clr;

    // Bit 0 steered by memory and simulated responses
    steerL = arlSrc[0] | diagFunc.diagArLoad;
    steerR = crmAr[2] | diagFunc.diagArLoad;
    arlSel[0] = (mclLoadAr | steerL) & (steerL | respAny);
    arlSel[1] = arlSrc[1] | ea36 | diagFunc.diagArLoad | fmArLoad;
    arlSel[2] = arlSrc[2];
    arrSel[0] = (mclLoadAr | steerR) & (steerR | respAny);
    arrSel[1] = crmAr[1] | dec.aread | diagFunc.diagArLoad | fmArLoad;
    arrSel[2] = crmAr[2];
    arxlSel[0] = (mclLoadArx | crmArx[2]) & (crmArx[2] | respAny);
    arxlSel[1] = crmArx[1] | fmArxLoad;
    arxlSel[2] = crmArx[2];
    arxrSel = arxlSel;

    loadAny = ar00to11Clr | (|arlSel);
    ar00to08Load = dec.arllLoad | regCtl[0] | loadAny | (crmMagic[0] & arlInd);
    ar09to17Load = dec.arlrLoad | regCtl[1] | loadAny;
    arrLoad = dec.arrLoad | regCtl[2] | (|arrSel) | arrClr;
    arxLoad = crmArx[0] | arxrSel[1] | arxrSel[2] | arxClr | mrReset;
  end

endmodule

//--- ctlDecodeIf.sv
`timescale 1ns/1ps

interface ctlDecodeIf;
  // Dispatch strobes
  logic aread, nicond, eaMod, mul, div, norm;
  // Special function strobes
  logic arlInd, saveFlags, flagCtl, scmAlt, clrFpd, spMemCycle, stackUpdate, mqShift;
  // Condition strobes, already gated by the condition enable
  logic arllLoad, arlrLoad, arrLoad, arClr, arxClr, arlIndCond, regCtl;

  modport dec (
    output aread, nicond, eaMod, mul, div, norm,
    output arlInd, saveFlags, flagCtl, scmAlt, clrFpd, spMemCycle, stackUpdate, mqShift,
    output arllLoad, arlrLoad, arrLoad, arClr, arxClr, arlIndCond, regCtl
  );

  modport user (
    input aread, nicond, eaMod, mul, div, norm,
    input arlInd, saveFlags, flagCtl, scmAlt, clrFpd, spMemCycle, stackUpdate, mqShift,
    input arllLoad, arlrLoad, arrLoad, arClr, arxClr, arlIndCond, regCtl
  );
endinterface

//--- ctlPkg.sv
package ctlPkg;

  // Microword fields use big-endian numbering, bit 0 is the MSB
  typedef logic [0:4] crmDispT;
  typedef logic [0:4] crmSpecT;
  typedef logic [0:5] crmCondT;
  typedef logic [0:8] crmMagicT;
  typedef logic [0:2] regSelT;

  // Diagnostic selector, bit 0 then two octal digits
  typedef logic [0:6] diagSelT;

  // Readback word, bus data bits 24 to 28
  typedef logic [0:4] statWordT;

  // Dispatch codes
  localparam crmDispT dispAread = 5'o02;
  localparam crmDispT dispReturn = 5'o03;
  localparam crmDispT dispNicond = 5'o06;
  localparam crmDispT dispMul = 5'o30;
  localparam crmDispT dispDiv = 5'o31;
  localparam crmDispT dispNorm = 5'o35;
  localparam crmDispT dispEaMod = 5'o36;

  // Special function codes
  localparam crmSpecT specMqShift = 5'o12;
  localparam crmSpecT specScmAlt = 5'o13;
  localparam crmSpecT specClrFpd = 5'o14;
  localparam crmSpecT specStackUpdate = 5'o20;
  localparam crmSpecT specArlInd = 5'o22;
  localparam crmSpecT specFlagCtl = 5'o24;
  localparam crmSpecT specSaveFlags = 5'o25;
  localparam crmSpecT specSpMemCycle = 5'o26;

  // Condition function, cond bits 3 to 5
  localparam logic [0:2] condArllLoad = 3'd1;
  localparam logic [0:2] condArlrLoad = 3'd2;
  localparam logic [0:2] condArrLoad = 3'd3;
  localparam logic [0:2] condArClr = 3'd4;
  localparam logic [0:2] condArxClr = 3'd5;
  localparam logic [0:2] condArlInd = 3'd6;
  localparam logic [0:2] condRegCtl = 3'd7;

  // Field order follows bus data 24..28
  typedef struct packed {
    logic memReset;
    logic channelClkStop;
    logic ldEbusReg;
    logic forceExtend;
    logic diag4;
  } diagRegT;

  typedef struct packed {
    logic ctl00x;
    logic ld04x;
    logic ld06x;
    logic ld07x;
    logic ld072;
    logic ld073;
    logic ld074;
    logic sync075;
    logic ld076;
    logic clkEdp;
    logic rd11x;
    logic rd12x;
    logic rd13x;
    logic rd14x;
    logic diagRead;
    logic diagArLoad;
  } diagFuncT;

endpackage

//--- ctlTop.sv
`timescale 1ns/1ps

module ctlTop (
  input  logic              CTL_DIAG_LD_FUNC_076,
  input  logic              rstN,
  input  ctlPkg::crmDispT   crmDisp,
  input  ctlPkg::crmSpecT   crmSpec,
  input  ctlPkg::crmCondT   crmCond,
  input  ctlPkg::crmMagicT  crmMagic,
  input  ctlPkg::regSelT    crmAr,
  input  ctlPkg::regSelT    crmArx,
  input  logic              condEn,
  input  logic              condDiagFunc,
  input  logic              mrReset,
  input  logic              mclLoadAr,
  input  logic              mclLoadArx,
  input  logic              mclMemArlInd,
  input  logic              mcl18BitEa,
  input  logic              mcl23BitEa,
  input  logic              fmXfer,
  input  logic              respMbox,
  input  logic              respSim,
  input  logic              arx18,
  input  ctlPkg::diagSelT   ebusDs,
  input  logic              diagStrobe,
  input  ctlPkg::statWordT  ebusDataIn,
  output logic              ar00to08Load,
  output logic              ar09to17Load,
  output logic              arrLoad,
  output logic              arxLoad,
  output ctlPkg::regSelT    arlSel,
  output ctlPkg::regSelT    arrSel,
  output ctlPkg::regSelT    arxlSel,
  output ctlPkg::regSelT    arxrSel,
  output logic              ar00to11Clr,
  output logic              ar12to17Clr,
  output logic              arrClr,
  output logic              arxClr,
  output ctlPkg::diagFuncT  diagFunc,
  output logic              ebusDriving,
  output ctlPkg::statWordT  ebusDataOut,
  output logic              channelClkStop,
  output logic              forceExtend,
  output logic              ldEbusReg
);
  import ctlPkg::*;

  diagSelT curSel;

  ctlDecodeIf decIf ();

  microDecode uMicroDecode (
    .crmDisp(crmDisp), .crmSpec(crmSpec), .crmCond(crmCond), .condEn(condEn), .dec(decIf.dec)
  );

  diagFuncDecode uDiagFuncDecode (
    .ebusDs(ebusDs), .diagStrobe(diagStrobe), .condDiagFunc(condDiagFunc),
    .crmMagic(crmMagic), .diagFunc(diagFunc), .curSel(curSel)
  );

  arLoadCtl uArLoadCtl (
    .dec(decIf.user), .crmAr(crmAr), .crmArx(crmArx), .crmMagic(crmMagic),
    .mrReset(mrReset), .mclLoadAr(mclLoadAr), .mclLoadArx(mclLoadArx),
    .mclMemArlInd(mclMemArlInd), .mcl18BitEa(mcl18BitEa), .mcl23BitEa(mcl23BitEa),
    .fmXfer(fmXfer), .respMbox(respMbox), .respSim(respSim), .arx18(arx18),
    .diagFunc(diagFunc), .ar00to08Load(ar00to08Load), .ar09to17Load(ar09to17Load),
    .arrLoad(arrLoad), .arxLoad(arxLoad), .arlSel(arlSel), .arrSel(arrSel),
    .arxlSel(arxlSel), .arxrSel(arxrSel), .ar00to11Clr(ar00to11Clr),
    .ar12to17Clr(ar12to17Clr), .arrClr(arrClr), .arxClr(arxClr)
  );

  diagRegReadback uDiagRegReadback (
    .CTL_DIAG_LD_FUNC_076(CTL_DIAG_LD_FUNC_076), .rstN(rstN), .diagFunc(diagFunc),
    .curSel(curSel), .ebusDataIn(ebusDataIn), .dec(decIf.user),
    .ar00to08Load(ar00to08Load), .ar09to17Load(ar09to17Load), .arrLoad(arrLoad),
    .arxLoad(arxLoad), .arlSel(arlSel), .arrSel(arrSel), .arxlSel(arxlSel),
    .arxrSel(arxrSel), .ar00to11Clr(ar00to11Clr), .ar12to17Clr(ar12to17Clr),
    .arrClr(arrClr), .arxClr(arxClr), .ebusDriving(ebusDriving),
    .ebusDataOut(ebusDataOut), .channelClkStop(channelClkStop),
    .forceExtend(forceExtend), .ldEbusReg(ldEbusReg)
  );

endmodule

//--- diagFuncDecode.sv
`timescale 1ns/1ps

module diagFuncDecode (
  input  ctlPkg::diagSelT   ebusDs,
  input  logic              diagStrobe,
  input  logic              condDiagFunc,
  input  ctlPkg::crmMagicT  crmMagic,
  output ctlPkg::diagFuncT  diagFunc,
  output ctlPkg::diagSelT   curSel
);

  logic consoleCtl;
  logic readStrobe;
  logic ldEn;
  logic rdEn;

  always_comb begin
    // Console owns the selector when either top bit is set
    consoleCtl = ebusDs[0] | ebusDs[1];
    curSel = consoleCtl ? ebusDs : crmMagic[2:8];
    readStrobe = consoleCtl ? diagStrobe : condDiagFunc;

    // Loads always come from the console bus
    ldEn = ebusDs[0] & diagStrobe;
    diagFunc.ctl00x = ldEn && (ebusDs[1:3] == 3'o0);
    diagFunc.ld04x = ldEn && (ebusDs[1:3] == 3'o4);
    diagFunc.ld06x = ldEn && (ebusDs[1:3] == 3'o6);
    diagFunc.ld07x = ldEn && (ebusDs[1:3] == 3'o7);

    // 07x sub-functions
    diagFunc.ld072 = diagFunc.ld07x && (ebusDs[4:6] == 3'o2);
    diagFunc.ld073 = diagFunc.ld07x && (ebusDs[4:6] == 3'o3);
    diagFunc.ld074 = diagFunc.ld07x && (ebusDs[4:6] == 3'o4);
    diagFunc.sync075 = diagFunc.ld07x && (ebusDs[4:6] == 3'o5);
    diagFunc.ld076 = diagFunc.ld07x && (ebusDs[4:6] == 3'o6);
    diagFunc.clkEdp = diagFunc.ld07x && (ebusDs[4:6] == 3'o7);

    // Reads use the selected source
    rdEn = curSel[0] & readStrobe;
    diagFunc.diagRead = rdEn && (curSel[1:3] == 3'o0);
    diagFunc.rd11x = rdEn && (curSel[1:3] == 3'o1);
    diagFunc.rd12x = rdEn && (curSel[1:3] == 3'o2);
    diagFunc.rd13x = rdEn && (curSel[1:3] == 3'o3);
    diagFunc.rd14x = rdEn && (curSel[1:3] == 3'o4);

    // Selector 177
    diagFunc.diagArLoad = curSel[0] & (&curSel[1:6]);
  end

endmodule

//--- diagRegReadback.sv
`timescale 1ns/1ps

module diagRegReadback (
  input  logic              CTL_DIAG_LD_FUNC_076,
  input  logic              rstN,
  input  ctlPkg::diagFuncT  diagFunc,
  input  ctlPkg::diagSelT   curSel,
  input  ctlPkg::statWordT  ebusDataIn,
  ctlDecodeIf.user          dec,
  input  logic              ar00to08Load,
  input  logic              ar09to17Load,
  input  logic              arrLoad,
  input  logic              arxLoad,
  input  ctlPkg::regSelT    arlSel,
  input  ctlPkg::regSelT    arrSel,
  input  ctlPkg::regSelT    arxlSel,
  input  ctlPkg::regSelT    arxrSel,
  input  logic              ar00to11Clr,
  input  logic              ar12to17Clr,
  input  logic              arrClr,
  input  logic              arxClr,
  output logic              ebusDriving,
  output ctlPkg::statWordT  ebusDataOut,
  output logic              channelClkStop,
  output logic              forceExtend,
  output logic              ldEbusReg
);
  import ctlPkg::*;

  diagRegT diagReg;

  // Written by diagnostic function 076
  always_ff @(posedge CTL_DIAG_LD_FUNC_076) begin
    if (!rstN) begin
      diagReg <= '0;
    end else if (diagFunc.ld076) begin
      diagReg <= diagRegT'(ebusDataIn);
    end
  end

  assign channelClkStop = diagReg.channelClkStop;
  assign forceExtend = diagReg.forceExtend;
  assign ldEbusReg = diagReg.ldEbusReg;
  assign ebusDriving = diagFunc.diagRead;

  // Read 10x, low digit picks the status word
  always_comb begin
    ebusDataOut = '0;
    if (diagFunc.diagRead) begin
      case (curSel[4:6])
        3'o0: ebusDataOut = {dec.scmAlt, dec.saveFlags, arlSel[1], arrLoad, ar00to08Load};
        3'o1: ebusDataOut = {dec.clrFpd, dec.arlInd, arlSel[0], arrLoad, ar09to17Load};
        3'o2: ebusDataOut = {dec.stackUpdate, dec.regCtl, arrSel[1], arxClr, arxLoad};
        3'o3: ebusDataOut = {dec.mqShift, dec.aread, arrSel[0], arrClr, arlSel[2]};
        3'o4: ebusDataOut = {dec.flagCtl, dec.nicond, arxlSel[1], dec.arClr, ar00to11Clr};
        3'o5: ebusDataOut = {dec.spMemCycle, dec.eaMod, arxlSel[0], diagReg.forceExtend,
                             ar12to17Clr};
        3'o6: ebusDataOut = {dec.mul, dec.div, arxrSel[1], diagReg.channelClkStop, arrClr};
        default: ebusDataOut = {dec.norm, diagReg.memReset, arxrSel[0], diagReg.ldEbusReg,
                                diagReg.diag4};
      endcase
    end
  end

endmodule

//--- list.f
+incdir+.
ctlPkg.sv
ctlDecodeIf.sv
microDecode.sv
arLoadCtl.sv
diagFuncDecode.sv
diagRegReadback.sv
ctlTop.sv
tbCtl.sv

//--- microDecode.sv
`timescale 1ns/1ps

module microDecode (
  input  ctlPkg::crmDispT crmDisp,
  input  ctlPkg::crmSpecT crmSpec,
  input  ctlPkg::crmCondT crmCond,
  input  logic            condEn,
  ctlDecodeIf.dec         dec
);
  import ctlPkg::*;

  logic [0:2] condFunc;

  // Dispatch field
  assign dec.aread = (crmDisp == dispAread);
  assign dec.nicond = (crmDisp == dispNicond);
  assign dec.eaMod = (crmDisp == dispEaMod);
  assign dec.mul = (crmDisp == dispMul);
  assign dec.div = (crmDisp == dispDiv);
  assign dec.norm = (crmDisp == dispNorm);

  // Special function field
  assign dec.arlInd = (crmSpec == specArlInd);
  assign dec.saveFlags = (crmSpec == specSaveFlags);
  assign dec.flagCtl = (crmSpec == specFlagCtl);
  assign dec.scmAlt = (crmSpec == specScmAlt);
  assign dec.clrFpd = (crmSpec == specClrFpd);
  assign dec.spMemCycle = (crmSpec == specSpMemCycle);
  assign dec.stackUpdate = (crmSpec == specStackUpdate);
  assign dec.mqShift = (crmSpec == specMqShift);

  // Only the low three bits pick the function
  assign condFunc = crmCond[3:5];

  assign dec.arllLoad = condEn & (condFunc == condArllLoad);
  assign dec.arlrLoad = condEn & (condFunc == condArlrLoad);
  assign dec.arrLoad = condEn & (condFunc == condArrLoad);
  assign dec.arClr = condEn & (condFunc == condArClr);
  assign dec.arxClr = condEn & (condFunc == condArxClr);
  assign dec.arlIndCond = condEn & (condFunc == condArlInd);
  assign dec.regCtl = condEn & (condFunc == condRegCtl);

endmodule

//--- tbCtlModel.svh
typedef struct packed {
  logic ar00to08Load, ar09to17Load, arrLoad, arxLoad;
  regSelT arlSel, arrSel, arxlSel, arxrSel;
  logic ar00to11Clr, ar12to17Clr, arrClr, arxClr;
} arCtlT;

function automatic logic condHit(input logic [0:2] code);
  return condEn & (crmCond[3:5] == code);
endfunction

// Console owns the selector when either top bit is set
function automatic diagSelT modelCurSel();
  return (ebusDs[0] | ebusDs[1]) ? ebusDs : crmMagic[2:8];
endfunction

function automatic diagFuncT modelDiagFunc();
  diagFuncT f;
  diagSelT sel;
  logic ld, rd;
  sel = modelCurSel();
  ld = ebusDs[0] & diagStrobe;
  rd = sel[0] & ((ebusDs[0] | ebusDs[1]) ? diagStrobe : condDiagFunc);
  f = '0;
  f.ctl00x = ld & (ebusDs[1:3] == 3'o0);
  f.ld04x = ld & (ebusDs[1:3] == 3'o4);
  f.ld06x = ld & (ebusDs[1:3] == 3'o6);
  f.ld07x = ld & (ebusDs[1:3] == 3'o7);
  f.ld072 = f.ld07x & (ebusDs[4:6] == 3'o2);
  f.ld073 = f.ld07x & (ebusDs[4:6] == 3'o3);
  f.ld074 = f.ld07x & (ebusDs[4:6] == 3'o4);
  f.sync075 = f.ld07x & (ebusDs[4:6] == 3'o5);
  f.ld076 = f.ld07x & (ebusDs[4:6] == 3'o6);
  f.clkEdp = f.ld07x & (ebusDs[4:6] == 3'o7);
  f.diagRead = rd & (sel[1:3] == 3'o0);
  f.rd11x = rd & (sel[1:3] == 3'o1);
  f.rd12x = rd & (sel[1:3] == 3'o2);
  f.rd13x = rd & (sel[1:3] == 3'o3);
  f.rd14x = rd & (sel[1:3] == 3'o4);
  f.diagArLoad = (sel == 7'o177);
  return f;
endfunction

function automatic arCtlT modelAr();
  arCtlT r;
  diagFuncT f;
  logic ind, resp, dal, arClr, fmAr, fmArx, aread;
  regSelT src, rc;
  f = modelDiagFunc();
  dal = f.diagArLoad;
  ind = mclMemArlInd | (crmSpec == specArlInd) | condHit(condArlInd);
  resp = respMbox | respSim;
  fmAr = fmXfer & mclLoadAr;
  fmArx = fmXfer & mclLoadArx;
  aread = (crmDisp == dispAread);
  rc = condHit(condRegCtl) ? crmMagic[0:2] : 3'b000;
  // Indirect mode takes ARL select and clears from magic
  src = ind ? {crmMagic[8], crmMagic[7], crmMagic[6]} : crmAr;
  r.arxClr = ind ? crmMagic[3] : condHit(condArxClr);
  arClr = ind ? crmMagic[4] : condHit(condArClr);
  r.arrClr = ind ? crmMagic[5] : condHit(condArClr);
  r.ar12to17Clr = mrReset | mcl18BitEa | arClr | ((crmDisp == dispEaMod) & arx18);
  r.ar00to11Clr = r.ar12to17Clr | mcl23BitEa;
  r.arlSel = {src[0] | dal | (mclLoadAr & resp),
              src[1] | (aread & r.ar00to11Clr) | dal | fmAr, src[2]};
  r.arrSel = {crmAr[2] | dal | (mclLoadAr & resp), crmAr[1] | aread | dal | fmAr, crmAr[2]};
  r.arxlSel = {crmArx[2] | (mclLoadArx & resp), crmArx[1] | fmArx, crmArx[2]};
  r.arxrSel = r.arxlSel;
  r.ar00to08Load = condHit(condArllLoad) | rc[0] | r.ar00to11Clr | (|r.arlSel) |
                   (crmMagic[0] & ind);
  r.ar09to17Load = condHit(condArlrLoad) | rc[1] | r.ar00to11Clr | (|r.arlSel);
  r.arrLoad = condHit(condArrLoad) | rc[2] | (|r.arrSel) | r.arrClr;
  r.arxLoad = crmArx[0] | r.arxrSel[1] | r.arxrSel[2] | r.arxClr | mrReset;
  return r;
endfunction

function automatic statWordT modelStat();
  arCtlT a;
  diagFuncT f;
  diagSelT sel;
  a = modelAr();
  f = modelDiagFunc();
  sel = modelCurSel();
  if (!f.diagRead) return '0;
  case (sel[4:6])
    3'o0: return {crmSpec == specScmAlt, crmSpec == specSaveFlags, a.arlSel[1], a.arrLoad,
                  a.ar00to08Load};
    3'o1: return {crmSpec == specClrFpd, crmSpec == specArlInd, a.arlSel[0], a.arrLoad,
                  a.ar09to17Load};
    3'o2: return {crmSpec == specStackUpdate, condHit(condRegCtl), a.arrSel[1], a.arxClr,
                  a.arxLoad};
    3'o3: return {crmSpec == specMqShift, crmDisp == dispAread, a.arrSel[0], a.arrClr,
                  a.arlSel[2]};
    3'o4: return {crmSpec == specFlagCtl, crmDisp == dispNicond, a.arxlSel[1],
                  condHit(condArClr), a.ar00to11Clr};
    3'o5: return {crmSpec == specSpMemCycle, crmDisp == dispEaMod, a.arxlSel[0],
                  mReg.forceExtend, a.ar12to17Clr};
    3'o6: return {crmDisp == dispMul, crmDisp == dispDiv, a.arxrSel[1], mReg.channelClkStop,
                  a.arrClr};
    default: return {crmDisp == dispNorm, mReg.memReset, a.arxrSel[0], mReg.ldEbusReg,
                     mReg.diag4};
  endcase
endfunction

task automatic checkBit(input string name, input logic got, input logic exp);
  checkCount++;
  if (got !== exp) begin
    errCount++;
    $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic checkSel(input string name, input regSelT got, input regSelT exp);
  checkCount++;
  if (got !== exp) begin
    errCount++;
    $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic checkStat(input string name, input statWordT got, input statWordT exp);
  checkCount++;
  if (got !== exp) begin
    errCount++;
    $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic checkFunc(input string name, input diagFuncT got, input diagFuncT exp);
  checkCount++;
  if (got !== exp) begin
    errCount++;
    $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
  end
endtask

//--- tbCtl.sv
`timescale 1ns/1ps

module tbCtl;
  import ctlPkg::*;

  logic CTL_DIAG_LD_FUNC_076, rstN;
  crmDispT crmDisp;
  crmSpecT crmSpec;
  crmCondT crmCond;
  crmMagicT crmMagic;
  regSelT crmAr, crmArx;
  logic condEn, condDiagFunc, mrReset, mclLoadAr, mclLoadArx, mclMemArlInd;
  logic mcl18BitEa, mcl23BitEa, fmXfer, respMbox, respSim, arx18;
  diagSelT ebusDs;
  logic diagStrobe;
  statWordT ebusDataIn;
  logic ar00to08Load, ar09to17Load, arrLoad, arxLoad;
  regSelT arlSel, arrSel, arxlSel, arxrSel;
  logic ar00to11Clr, ar12to17Clr, arrClr, arxClr;
  diagFuncT diagFunc;
  logic ebusDriving;
  statWordT ebusDataOut;
  logic channelClkStop, forceExtend, ldEbusReg, idle, timedOut;
  int errCount, checkCount, cycles, startErr;
  diagRegT mReg;
  statWordT data;

  `include "tbCtlModel.svh"

  ctlTop u_dut (.*);

  always #10 CTL_DIAG_LD_FUNC_076 = ~CTL_DIAG_LD_FUNC_076;

  assign idle = (channelClkStop === 1'b0) && (forceExtend === 1'b0) && (ldEbusReg === 1'b0);

  // Model copy of the diagnostic register
  always @(posedge CTL_DIAG_LD_FUNC_076) begin : modelReg
    diagFuncT f;
    f = modelDiagFunc();
    if (!rstN) begin
      mReg <= '0;
    end else if (f.ld076) begin
      mReg <= ebusDataIn;
    end
  end

  task automatic randomVector();
    logic [31:0] a, b;
    a = $urandom;
    b = $urandom;
    {crmDisp, crmSpec, crmCond, crmMagic, crmAr, crmArx, condEn} = a;
    {mrReset, mclLoadAr, mclLoadArx, mclMemArlInd, mcl18BitEa, mcl23BitEa, fmXfer,
     respMbox, respSim, arx18, condDiagFunc, diagStrobe, ebusDs, ebusDataIn} = b[23:0];
    // Keep master reset rare so the other clears show
    mrReset = mrReset & b[24] & b[25];
  endtask

  task automatic checkAll();
    arCtlT e;
    diagFuncT f;
    e = modelAr();
    f = modelDiagFunc();
    checkBit("ar00to08Load", ar00to08Load, e.ar00to08Load);
    checkBit("ar09to17Load", ar09to17Load, e.ar09to17Load);
    checkBit("arrLoad", arrLoad, e.arrLoad);
    checkBit("arxLoad", arxLoad, e.arxLoad);
    checkSel("arlSel", arlSel, e.arlSel);
    checkSel("arrSel", arrSel, e.arrSel);
    checkSel("arxlSel", arxlSel, e.arxlSel);
    checkSel("arxrSel", arxrSel, e.arxrSel);
    checkBit("ar00to11Clr", ar00to11Clr, e.ar00to11Clr);
    checkBit("ar12to17Clr", ar12to17Clr, e.ar12to17Clr);
    checkBit("arrClr", arrClr, e.arrClr);
    checkBit("arxClr", arxClr, e.arxClr);
    checkFunc("diagFunc", diagFunc, f);
    checkBit("ebusDriving", ebusDriving, f.diagRead);
    checkStat("ebusDataOut", ebusDataOut, modelStat());
    checkBit("channelClkStop", channelClkStop, mReg.channelClkStop);
    checkBit("forceExtend", forceExtend, mReg.forceExtend);
    checkBit("ldEbusReg", ldEbusReg, mReg.ldEbusReg);
  endtask

  // Sample mid low phase, then move to the next falling edge
  task automatic applyAndCheck();
    #5;
    checkAll();
    @(negedge CTL_DIAG_LD_FUNC_076);
  endtask

  task automatic registerHolds(input statWordT value);
    checkBit("channelClkStop", channelClkStop, value[1]);
    checkBit("ldEbusReg", ldEbusReg, value[2]);
    checkBit("forceExtend", forceExtend, value[3]);
  endtask

  task automatic reportTest(input string name, input int errBefore);
    $display("%s: %s, %0d errors", name, (errCount == errBefore) ? "ok" : "bad",
             errCount - errBefore);
  endtask

  initial begin
    errCount = 0;
    checkCount = 0;
    timedOut = 1'b0;
    void'($urandom(4));
    CTL_DIAG_LD_FUNC_076 = 1'b0;
    rstN = 1'b0;
    randomVector();
    diagStrobe = 1'b0;
    repeat (2) @(posedge CTL_DIAG_LD_FUNC_076);
    @(negedge CTL_DIAG_LD_FUNC_076);
    rstN = 1'b1;
    // Register must be clear right after reset
    startErr = errCount;
    registerHolds('0);
    cycles = 0;
    while (!idle && cycles < 10) begin
      @(negedge CTL_DIAG_LD_FUNC_076);
      cycles++;
    end
    if (!idle) begin
      timedOut = 1'b1;
      $display("Diagnostic outputs did not go idle within 10 cycles after reset");
    end
    if (!timedOut) begin
      for (int sub = 0; sub < 8; sub++) begin
        ebusDs = '0;
        condDiagFunc = 1'b1;
        crmMagic[2:8] = {4'b1000, sub[2:0]};
        applyAndCheck();
      end
      reportTest("reset and idle readback", startErr);

      startErr = errCount;
      repeat (300) begin
        randomVector();
        applyAndCheck();
      end
      reportTest("random AR load and select", startErr);

      startErr = errCount;
      repeat (300) begin
        randomVector();
        if (crmArx[0]) begin
          ebusDs[0:1] = 2'b00;
        end
        applyAndCheck();
      end
      reportTest("diagnostic function decode", startErr);

      startErr = errCount;
      repeat (20) begin
        randomVector();
        ebusDs = 7'o176;
        diagStrobe = 1'b1;
        data = ebusDataIn;
        applyAndCheck();
        randomVector();
        ebusDs = 7'o176;
        diagStrobe = 1'b0;
        #5;
        registerHolds(data);
        checkAll();
        @(negedge CTL_DIAG_LD_FUNC_076);
        registerHolds(data);
      end
      reportTest("diagnostic register load", startErr);

      startErr = errCount;
      for (int sub = 0; sub < 8; sub++) begin
        randomVector();
        ebusDs = {4'b1000, sub[2:0]};
        diagStrobe = 1'b1;
        applyAndCheck();
      end
      repeat (100) begin
        randomVector();
        ebusDs[0] = 1'b1;
        if (ebusDs[1:3] == 3'o0) begin
          ebusDs[1:3] = 3'o1;
        end
        #5;
        checkBit("ebusDriving", ebusDriving, 1'b0);
        checkStat("ebusDataOut", ebusDataOut, '0);
        checkAll();
        @(negedge CTL_DIAG_LD_FUNC_076);
      end
      reportTest("status readback", startErr);
    end
    $display("Checks run %0d, errors %0d", checkCount, errCount);
    if (errCount == 0 && !timedOut) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
